// ==== common/isa_pkg.sv ====
package isa_pkg;

    localparam int xlen = 32;
    localparam int reg_addr_w = 5;

    // Instruction field positions
    localparam int rd_lsb = 7;
    localparam int funct3_lsb = 12;
    localparam int rs1_lsb = 15;
    localparam int rs2_lsb = 20;
    localparam int funct7_alt = 30;

    typedef enum logic [6:0] {
        opc_op     = 7'b0110011,
        opc_op_imm = 7'b0010011,
        opc_lui    = 7'b0110111,
        opc_auipc  = 7'b0010111,
        opc_jal    = 7'b1101111,
        opc_jalr   = 7'b1100111,
        opc_branch = 7'b1100011,
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011
    } opcode_e;

    // Branch compare
    localparam logic [2:0] f3_beq = 3'b000;
    localparam logic [2:0] f3_bne = 3'b001;
    localparam logic [2:0] f3_blt = 3'b100;
    localparam logic [2:0] f3_bge = 3'b101;
    localparam logic [2:0] f3_bltu = 3'b110;
    localparam logic [2:0] f3_bgeu = 3'b111;

    // Loads and stores without the halfword forms
    localparam logic [2:0] f3_lb = 3'b000;
    localparam logic [2:0] f3_lw = 3'b010;
    localparam logic [2:0] f3_lbu = 3'b100;
    localparam logic [2:0] f3_sb = 3'b000;
    localparam logic [2:0] f3_sw = 3'b010;

    // ALU sub-functions shared by op and op_imm
    localparam logic [2:0] f3_add = 3'b000;
    localparam logic [2:0] f3_sll = 3'b001;
    localparam logic [2:0] f3_slt = 3'b010;
    localparam logic [2:0] f3_sltu = 3'b011;
    localparam logic [2:0] f3_xor = 3'b100;
    localparam logic [2:0] f3_srl = 3'b101;
    localparam logic [2:0] f3_or = 3'b110;
    localparam logic [2:0] f3_and = 3'b111;

endpackage

// ==== common/core_pkg.sv ====
package core_pkg;

    localparam logic [isa_pkg::xlen-1:0] reset_pc = '0;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_sltu,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_pass_b
    } alu_op_e;

    typedef enum logic [1:0] {
        a_rs1,
        a_pc,
        a_zero
    } alu_a_src_e;

    typedef enum logic {
        b_rs2,
        b_imm
    } alu_b_src_e;

    typedef enum logic [1:0] {
        wb_alu,
        wb_load,
        wb_pc4
    } wb_src_e;

    // Decoded control for the instruction in flight
    typedef struct packed {
        alu_op_e    alu_op;
        alu_a_src_e a_src;
        alu_b_src_e b_src;
        wb_src_e    wb_src;
        logic       reg_write;
        logic       mem_read;
        logic       mem_write;
        logic       is_branch;
        logic       is_jal;
        logic       is_jalr;
        logic [2:0] funct3;
    } ctrl_t;

    // Data port request of 69 bits
    typedef struct packed {
        logic [isa_pkg::xlen-1:0] addr;
        logic [isa_pkg::xlen-1:0] wdata;
        logic [3:0]               be;
        logic                     we;
    } dmem_req_t;

endpackage

// ==== decode/instr_decoder.sv ====
`timescale 1ns/1ps

module instr_decoder (
    input  logic [isa_pkg::xlen-1:0]       i_instr,
    output core_pkg::ctrl_t                o_ctrl,
    output logic [isa_pkg::reg_addr_w-1:0] o_rs1,
    output logic [isa_pkg::reg_addr_w-1:0] o_rs2,
    output logic [isa_pkg::reg_addr_w-1:0] o_rd,
    output logic [isa_pkg::xlen-1:0]       o_imm
);

    isa_pkg::opcode_e    opcode;
    logic [2:0]          funct3;
    logic                alt;
    core_pkg::alu_op_e   alu_f3;
    logic [isa_pkg::xlen-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;

    assign opcode = isa_pkg::opcode_e'(i_instr[6:0]);
    assign funct3 = i_instr[isa_pkg::funct3_lsb +: 3];
    assign alt = i_instr[isa_pkg::funct7_alt];

    assign o_rd = i_instr[isa_pkg::rd_lsb +: isa_pkg::reg_addr_w];
    assign o_rs1 = i_instr[isa_pkg::rs1_lsb +: isa_pkg::reg_addr_w];
    assign o_rs2 = i_instr[isa_pkg::rs2_lsb +: isa_pkg::reg_addr_w];

    assign imm_i = {{20{i_instr[31]}}, i_instr[31:20]};
    assign imm_s = {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
    assign imm_b = {{19{i_instr[31]}}, i_instr[31], i_instr[7], i_instr[30:25],
                    i_instr[11:8], 1'b0};
    assign imm_u = {i_instr[31:12], 12'b0};
    assign imm_j = {{11{i_instr[31]}}, i_instr[31], i_instr[19:12], i_instr[20],
                    i_instr[30:21], 1'b0};

    // ALU function; bit 30 is an immediate bit for addi, so only op uses it for sub
    always_comb begin
        case (funct3)
            isa_pkg::f3_add:  alu_f3 = (opcode == isa_pkg::opc_op && alt) ?
                                       core_pkg::alu_sub : core_pkg::alu_add;
            isa_pkg::f3_sll:  alu_f3 = core_pkg::alu_sll;
            isa_pkg::f3_slt:  alu_f3 = core_pkg::alu_slt;
            isa_pkg::f3_sltu: alu_f3 = core_pkg::alu_sltu;
            isa_pkg::f3_xor:  alu_f3 = core_pkg::alu_xor;
            isa_pkg::f3_srl:  alu_f3 = alt ? core_pkg::alu_sra : core_pkg::alu_srl;
            isa_pkg::f3_or:   alu_f3 = core_pkg::alu_or;
            default:          alu_f3 = core_pkg::alu_and;
        endcase
    end

    always_comb begin
        // Defaults describe a no-op
        o_ctrl.alu_op = core_pkg::alu_add;
        o_ctrl.a_src = core_pkg::a_rs1;
        o_ctrl.b_src = core_pkg::b_imm;
        o_ctrl.wb_src = core_pkg::wb_alu;
        o_ctrl.reg_write = 1'b0;
        o_ctrl.mem_read = 1'b0;
        o_ctrl.mem_write = 1'b0;
        o_ctrl.is_branch = 1'b0;
        o_ctrl.is_jal = 1'b0;
        o_ctrl.is_jalr = 1'b0;
        o_ctrl.funct3 = funct3;
        o_imm = imm_i;
        case (opcode)
            isa_pkg::opc_op: begin
                o_ctrl.alu_op = alu_f3;
                o_ctrl.b_src = core_pkg::b_rs2;
                o_ctrl.reg_write = 1'b1;
            end
            isa_pkg::opc_op_imm: begin
                o_ctrl.alu_op = alu_f3;
                o_ctrl.reg_write = 1'b1;
            end
            isa_pkg::opc_lui: begin
                o_ctrl.alu_op = core_pkg::alu_pass_b;
                o_ctrl.a_src = core_pkg::a_zero;
                o_ctrl.reg_write = 1'b1;
                o_imm = imm_u;
            end
            isa_pkg::opc_auipc: begin
                o_ctrl.a_src = core_pkg::a_pc;
                o_ctrl.reg_write = 1'b1;
                o_imm = imm_u;
            end
            isa_pkg::opc_jal: begin
                o_ctrl.wb_src = core_pkg::wb_pc4;
                o_ctrl.reg_write = 1'b1;
                o_ctrl.is_jal = 1'b1;
                o_imm = imm_j;
            end
            isa_pkg::opc_jalr: begin
                o_ctrl.wb_src = core_pkg::wb_pc4;
                o_ctrl.reg_write = 1'b1;
                o_ctrl.is_jalr = 1'b1;
            end
            isa_pkg::opc_branch: begin
                o_ctrl.is_branch = 1'b1;
                o_imm = imm_b;
            end
            isa_pkg::opc_load: begin
                o_ctrl.wb_src = core_pkg::wb_load;
                o_ctrl.reg_write = 1'b1;
                o_ctrl.mem_read = 1'b1;
            end
            isa_pkg::opc_store: begin
                o_ctrl.mem_write = 1'b1;
                o_imm = imm_s;
            end
            default: ;
        endcase
    end

endmodule

// ==== execute/execute_unit.sv ====
`timescale 1ns/1ps

module execute_unit (
    input  logic                     clk,
    input  logic                     rst_n,
    input  core_pkg::ctrl_t          i_ctrl,
    input  logic [isa_pkg::xlen-1:0] i_rs1_data,
    input  logic [isa_pkg::xlen-1:0] i_rs2_data,
    input  logic [isa_pkg::xlen-1:0] i_imm,
    output logic [isa_pkg::xlen-1:0] o_pc,
    output logic [isa_pkg::xlen-1:0] o_pc_plus4,
    output logic [isa_pkg::xlen-1:0] o_alu_result
);

    logic [isa_pkg::xlen-1:0] op_a, op_b;
    logic [isa_pkg::xlen-1:0] target_base, target_sum, target, pc_next;
    logic                     eq, lt_s, lt_u, taken;

    always_comb begin
        case (i_ctrl.a_src)
            core_pkg::a_pc:   op_a = o_pc;
            core_pkg::a_zero: op_a = '0;
            default:          op_a = i_rs1_data;
        endcase
        op_b = (i_ctrl.b_src == core_pkg::b_imm) ? i_imm : i_rs2_data;
    end

    always_comb begin
        case (i_ctrl.alu_op)
            core_pkg::alu_sub:    o_alu_result = op_a - op_b;
            core_pkg::alu_and:    o_alu_result = op_a & op_b;
            core_pkg::alu_or:     o_alu_result = op_a | op_b;
            core_pkg::alu_xor:    o_alu_result = op_a ^ op_b;
            core_pkg::alu_slt:    o_alu_result = {31'b0, $signed(op_a) < $signed(op_b)};
            core_pkg::alu_sltu:   o_alu_result = {31'b0, op_a < op_b};
            core_pkg::alu_sll:    o_alu_result = op_a << op_b[4:0];
            core_pkg::alu_srl:    o_alu_result = op_a >> op_b[4:0];
            core_pkg::alu_sra:    o_alu_result = $signed(op_a) >>> op_b[4:0];
            core_pkg::alu_pass_b: o_alu_result = op_b;
            default:              o_alu_result = op_a + op_b;
        endcase
    end

    // Branch comparator works on the raw register operands
    assign eq = (i_rs1_data == i_rs2_data);
    assign lt_s = ($signed(i_rs1_data) < $signed(i_rs2_data));
    assign lt_u = (i_rs1_data < i_rs2_data);

    always_comb begin
        case (i_ctrl.funct3)
            isa_pkg::f3_beq:  taken = eq;
            isa_pkg::f3_bne:  taken = !eq;
            isa_pkg::f3_blt:  taken = lt_s;
            isa_pkg::f3_bge:  taken = !lt_s;
            isa_pkg::f3_bltu: taken = lt_u;
            isa_pkg::f3_bgeu: taken = !lt_u;
            default:          taken = 1'b0;
        endcase
    end

    // Target adder clears bit 0 for jalr
    assign target_base = i_ctrl.is_jalr ? i_rs1_data : o_pc;
    assign target_sum = target_base + i_imm;
    assign target = {target_sum[isa_pkg::xlen-1:1], target_sum[0] & !i_ctrl.is_jalr};

    assign o_pc_plus4 = o_pc + 32'd4;
    assign pc_next = (i_ctrl.is_jal || i_ctrl.is_jalr || (i_ctrl.is_branch && taken)) ?
                     target : o_pc_plus4;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            o_pc <= core_pkg::reset_pc;
        end else begin
            o_pc <= pc_next;
        end
    end

endmodule

// ==== result/result_unit.sv ====
`timescale 1ns/1ps

module result_unit (
    input  core_pkg::ctrl_t          i_ctrl,
    input  logic [isa_pkg::xlen-1:0] i_alu_result,
    input  logic [isa_pkg::xlen-1:0] i_rs2_data,
    input  logic [isa_pkg::xlen-1:0] i_pc_plus4,
    input  logic [isa_pkg::xlen-1:0] i_dmem_rdata,
    output core_pkg::dmem_req_t      o_dmem_req,
    output logic [isa_pkg::xlen-1:0] o_wb_data
);

    logic [1:0]               lane;
    logic [7:0]               lane_byte;
    logic [isa_pkg::xlen-1:0] load_data;

    assign lane = i_alu_result[1:0];

    // Store side
    always_comb begin
        o_dmem_req.addr = {i_alu_result[isa_pkg::xlen-1:2], 2'b00};
        o_dmem_req.we = i_ctrl.mem_write;
        o_dmem_req.wdata = i_rs2_data;
        o_dmem_req.be = 4'b0000;
        if (i_ctrl.mem_write) begin
            case (i_ctrl.funct3)
                isa_pkg::f3_sb: begin
                    // Byte copied to every lane and the enables pick the lane written
                    o_dmem_req.wdata = {4{i_rs2_data[7:0]}};
                    o_dmem_req.be = 4'b0001 << lane;
                end
                isa_pkg::f3_sw: o_dmem_req.be = 4'b1111;
                default: ;
            endcase
        end
    end

    // Load side
    assign lane_byte = i_dmem_rdata[lane*8 +: 8];

    always_comb begin
        load_data = '0;
        if (i_ctrl.mem_read) begin
            case (i_ctrl.funct3)
                isa_pkg::f3_lb:  load_data = {{24{lane_byte[7]}}, lane_byte};
                isa_pkg::f3_lbu: load_data = {24'b0, lane_byte};
                isa_pkg::f3_lw:  load_data = i_dmem_rdata;
                default: ;
            endcase
        end
    end

    always_comb begin
        case (i_ctrl.wb_src)
            core_pkg::wb_load: o_wb_data = load_data;
            core_pkg::wb_pc4:  o_wb_data = i_pc_plus4;
            default:           o_wb_data = i_alu_result;
        endcase
    end

endmodule

// ==== src/regfile.sv ====
`timescale 1ns/1ps

module regfile (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic [isa_pkg::reg_addr_w-1:0] i_rs1,
    input  logic [isa_pkg::reg_addr_w-1:0] i_rs2,
    input  logic [isa_pkg::reg_addr_w-1:0] i_rd,
    input  logic                           i_we,
    input  logic [isa_pkg::xlen-1:0]       i_wdata,
    output logic [isa_pkg::xlen-1:0]       o_rs1_data,
    output logic [isa_pkg::xlen-1:0]       o_rs2_data
);

    logic [isa_pkg::xlen-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we && i_rd != '0) begin
            regs[i_rd] <= i_wdata;
        end
    end

    // x0 reads as zero
    assign o_rs1_data = (i_rs1 == '0) ? '0 : regs[i_rs1];
    assign o_rs2_data = (i_rs2 == '0) ? '0 : regs[i_rs2];

endmodule

// ==== src/core_top.sv ====
`timescale 1ns/1ps

module core_top (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [isa_pkg::xlen-1:0] i_instr,
    input  logic [isa_pkg::xlen-1:0] i_dmem_rdata,
    output logic [isa_pkg::xlen-1:0] o_pc,
    output core_pkg::dmem_req_t      o_dmem_req
);

    core_pkg::ctrl_t                ctrl;
    logic [isa_pkg::reg_addr_w-1:0] rs1, rs2, rd;
    logic [isa_pkg::xlen-1:0]       imm;
    logic [isa_pkg::xlen-1:0]       rs1_data, rs2_data;
    logic [isa_pkg::xlen-1:0]       alu_result, pc_plus4, wb_data;

    instr_decoder u_decoder (
        .i_instr (i_instr),
        .o_ctrl  (ctrl),
        .o_rs1   (rs1),
        .o_rs2   (rs2),
        .o_rd    (rd),
        .o_imm   (imm)
    );

    regfile u_regfile (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_rs1      (rs1),
        .i_rs2      (rs2),
        .i_rd       (rd),
        .i_we       (ctrl.reg_write),
        .i_wdata    (wb_data),
        .o_rs1_data (rs1_data),
        .o_rs2_data (rs2_data)
    );

    execute_unit u_execute (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_ctrl       (ctrl),
        .i_rs1_data   (rs1_data),
        .i_rs2_data   (rs2_data),
        .i_imm        (imm),
        .o_pc         (o_pc),
        .o_pc_plus4   (pc_plus4),
        .o_alu_result (alu_result)
    );

    // ALU result doubles as the data address
    result_unit u_result (
        .i_ctrl       (ctrl),
        .i_alu_result (alu_result),
        .i_rs2_data   (rs2_data),
        .i_pc_plus4   (pc_plus4),
        .i_dmem_rdata (i_dmem_rdata),
        .o_dmem_req   (o_dmem_req),
        .o_wb_data    (wb_data)
    );

endmodule

// ==== tests/core_assert.sv ====
`timescale 1ns/1ps

module core_assert (
    input logic                clk,
    input logic                rst_n,
    input logic [31:0]         i_pc,
    input core_pkg::dmem_req_t i_dmem_req
);

    // PC is cleared one edge after reset is first sampled
    a_reset_quiet: assert property (@(posedge clk)
        (!rst_n && !$past(rst_n)) |-> (i_pc == 32'h0 && !i_dmem_req.we))
        else $error("core_assert: PC or strobe active during reset");

    a_strobe_be: assert property (@(posedge clk)
        i_dmem_req.we |-> (i_dmem_req.be != 4'b0000))
        else $error("core_assert: write strobe with no byte enables");

    a_pc_aligned: assert property (@(posedge clk) i_pc[1:0] == 2'b00)
        else $error("core_assert: PC not word aligned");

endmodule

bind core_top core_assert u_core_assert (
    .clk        (clk),
    .rst_n      (rst_n),
    .i_pc       (o_pc),
    .i_dmem_req (o_dmem_req)
);

// ==== tests/tb_core.sv ====
`timescale 1ns/1ps

module tb_core;

    localparam int alu_cycles = 50;
    localparam int upper_cycles = 12;
    localparam int flow_cycles = 60;
    localparam int byte_cycles = 16;
    // Reset hold, RAM presets and release per test
    localparam int setup_cycles = 20;
    // The upper test runs twice
    localparam int total_cycles = alu_cycles + 2 * upper_cycles + flow_cycles + byte_cycles
                                  + 5 * setup_cycles;
    localparam logic [31:0] nop = 32'h0000_0013;

    logic                clk;
    logic                rst_n;
    logic [31:0]         instr;
    logic [31:0]         dmem_rdata;
    logic [31:0]         pc;
    core_pkg::dmem_req_t dmem_req;

    logic [31:0] rom [64];
    logic [31:0] ram [256];
    logic        preset_en;
    logic [7:0]  preset_idx;
    logic [31:0] preset_data;

    int          pc_idx;
    logic [31:0] exp_pc [$];
    logic [31:0] trace [$];
    logic [31:0] exp_addr [$];
    logic [31:0] exp_val [$];

    core_top UUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_instr      (instr),
        .i_dmem_rdata (dmem_rdata),
        .o_pc         (pc),
        .o_dmem_req   (dmem_req)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Instruction ROM and data RAM models
    always_comb instr = rom[pc[7:2]];
    assign dmem_rdata = ram[dmem_req.addr[9:2]];

    always @(posedge clk) begin
        if (preset_en) begin
            ram[preset_idx] <= preset_data;
        end else if (dmem_req.we) begin
            for (int b = 0; b < 4; b++) begin
                if (dmem_req.be[b]) begin
                    ram[dmem_req.addr[9:2]][8*b +: 8] <= dmem_req.wdata[8*b +: 8];
                end
            end
        end
    end

    initial begin
        #(total_cycles * 8 * 2);
        $display("Run timed out before all tests finished");
        $display("TB FAILED");
        $fatal(1);
    end

    function automatic logic [31:0] enc_r(logic [31:0] f3, alt, rd, rs1, rs2);
        return {1'b0, alt[0], 5'b0, rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'h33};
    endfunction

    function automatic logic [31:0] enc_i(logic [31:0] opc, f3, rd, rs1, imm);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc[6:0]};
    endfunction

    function automatic logic [31:0] enc_s(logic [31:0] f3, rs2, rs1, imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], 7'h23};
    endfunction

    function automatic logic [31:0] enc_b(logic [31:0] f3, rs1, rs2, off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], 7'h63};
    endfunction

    function automatic logic [31:0] enc_u(logic [31:0] opc, rd, imm20);
        return {imm20[19:0], rd[4:0], opc[6:0]};
    endfunction

    function automatic logic [31:0] enc_j(logic [31:0] rd, off);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'h6f};
    endfunction

    function automatic logic [31:0] sext12(logic [31:0] x);
        return {{20{x[11]}}, x[11:0]};
    endfunction

    // RV32I reference results
    function automatic logic [31:0] alu_ref(logic [31:0] f3, alt, a, b);
        case (f3[2:0])
            3'd0: return alt[0] ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return {31'b0, $signed(a) < $signed(b)};
            3'd3: return {31'b0, a < b};
            3'd4: return a ^ b;
            3'd5: return alt[0] ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic bit branch_ref(logic [31:0] f3, a, b);
        case (f3[2:0])
            3'd0: return a == b;
            3'd1: return a != b;
            3'd4: return $signed(a) < $signed(b);
            3'd5: return $signed(a) >= $signed(b);
            3'd6: return a < b;
            default: return a >= b;
        endcase
    endfunction

    task automatic check(string name, logic [31:0] expected, logic [31:0] actual);
        if (expected !== actual) begin
            $display("ERROR %s: expected %h, actual %h", name, expected, actual);
            $display("TB FAILED");
            $fatal(1);
        end
    endtask

    task automatic emit(logic [31:0] word);
        rom[pc_idx] = word;
        exp_pc.push_back(pc_idx * 4);
        pc_idx++;
    endtask

    // Placed in ROM but never executed
    task automatic skip(logic [31:0] word);
        rom[pc_idx] = word;
        pc_idx++;
    endtask

    task automatic store_word(logic [31:0] rs2, logic [31:0] addr, logic [31:0] value);
        emit(enc_s(2, rs2, 0, addr));
        exp_addr.push_back(addr);
        exp_val.push_back(value);
    endtask

    task automatic load_imm(logic [31:0] rd, logic [31:0] value);
        emit(enc_u(32'h37, rd, (value + 32'h800) >> 12));
        emit(enc_i(32'h13, 0, rd, rd, value));
    endtask

    task automatic preset(logic [31:0] addr, logic [31:0] data);
        @(posedge clk);
        preset_en <= 1'b1;
        preset_idx <= addr[9:2];
        preset_data <= data;
        @(posedge clk);
        preset_en <= 1'b0;
    endtask

    // Core held in reset while the next program is loaded
    task automatic hold_reset();
        @(posedge clk);
        rst_n <= 1'b0;
        @(posedge clk);
        repeat (9) begin
            @(negedge clk);
            check("reset pc", 32'h0, pc);
            check("reset strobe", 32'h0, {31'b0, dmem_req.we});
        end
        for (int i = 0; i < 64; i++) begin
            rom[i] = nop;
        end
        pc_idx = 0;
        exp_pc.delete();
        exp_addr.delete();
        exp_val.delete();
    endtask

    task automatic run_program(string name, int cycles);
        emit(enc_j(0, 0));
        @(posedge clk);
        rst_n <= 1'b1;
        trace.delete();
        repeat (cycles) begin
            @(negedge clk);
            trace.push_back(pc);
        end
        check({name, " first fetch"}, 32'h0, trace[0]);
        foreach (exp_addr[i]) begin
            check(name, exp_val[i], ram[exp_addr[i][9:2]]);
        end
    endtask

    task automatic test_alu();
        logic [31:0] a, b, f3, alt, imm;
        hold_reset();
        a = $urandom;
        b = $urandom;
        load_imm(1, a);
        load_imm(2, b);
        for (int k = 0; k < 10; k++) begin
            f3 = (k < 8) ? k : ((k == 8) ? 0 : 5);
            alt = (k >= 8) ? 1 : 0;
            emit(enc_r(f3, alt, 3, 1, 2));
            store_word(3, 4 * k, alu_ref(f3, alt, a, b));
        end
        // Immediate forms with srai last
        for (int j = 0; j < 9; j++) begin
            f3 = (j < 8) ? j : 5;
            alt = (j == 8) ? 1 : 0;
            if (f3 == 1 || f3 == 5) begin
                imm = (alt << 10) | ($urandom & 32'h1f);
            end else begin
                imm = $urandom & 32'hfff;
            end
            emit(enc_i(32'h13, f3, 3, 1, imm));
            store_word(3, 32'h40 + 4 * j, alu_ref(f3, alt, a, sext12(imm)));
        end
        run_program("alu", alu_cycles);
    endtask

    task automatic test_upper();
        logic [31:0] u1, u2, pc_auipc;
        hold_reset();
        preset(32'h108, 32'hffff_ffff);
        u1 = $urandom & 32'hfffff;
        u2 = $urandom & 32'hfffff;
        emit(enc_u(32'h37, 5, u1));
        store_word(5, 32'h100, u1 << 12);
        pc_auipc = pc_idx * 4;
        emit(enc_u(32'h17, 6, u2));
        store_word(6, 32'h104, (u2 << 12) + pc_auipc);
        emit(enc_i(32'h13, 0, 0, 0, 32'h123));
        store_word(0, 32'h108, 32'h0);
        run_program("upper", upper_cycles);
    endtask

    task automatic test_flow();
        int          br_f3 [6] = '{0, 1, 4, 5, 6, 7};
        logic [31:0] rs1, rs2, pj, q;
        hold_reset();
        load_imm(1, 32'd5);
        load_imm(2, 32'hffff_fffd);
        // Operand pairs (x1,x2), (x2,x1), (x1,x1) cover both outcomes per type
        foreach (br_f3[i]) begin
            for (int p = 0; p < 3; p++) begin
                rs1 = (p == 1) ? 2 : 1;
                rs2 = (p == 0) ? 2 : 1;
                emit(enc_b(br_f3[i], rs1, rs2, 8));
                if (branch_ref(br_f3[i], (rs1 == 1) ? 32'd5 : 32'hffff_fffd,
                               (rs2 == 1) ? 32'd5 : 32'hffff_fffd)) begin
                    skip(nop);
                end else begin
                    emit(nop);
                end
            end
        end
        pj = pc_idx * 4;
        emit(enc_j(10, 12));
        skip(nop);
        skip(nop);
        q = pc_idx * 4;
        emit(enc_u(32'h17, 11, 0));
        emit(enc_i(32'h67, 0, 12, 11, 16));
        skip(nop);
        skip(nop);
        store_word(10, 32'h200, pj + 4);
        store_word(12, 32'h204, q + 8);
        run_program("flow", flow_cycles);
        foreach (exp_pc[i]) begin
            check("flow pc", exp_pc[i], trace[i]);
        end
    endtask

    task automatic test_bytes();
        logic [31:0] val, word, expected;
        hold_reset();
        val = $urandom;
        load_imm(1, val);
        for (int k = 0; k < 4; k++) begin
            word = $urandom;
            word[8*k +: 8] = ~val[7:0];
            preset(32'h300 + 4 * k, word);
            expected = word;
            expected[8*k +: 8] = val[7:0];
            emit(enc_s(0, 1, 0, 32'h300 + 5 * k));
            exp_addr.push_back(32'h300 + 4 * k);
            exp_val.push_back(expected);
        end
        // Byte 2 of this word has bit 7 set
        word = $urandom | 32'h0080_0000;
        preset(32'h320, word);
        emit(enc_i(32'h03, 0, 3, 0, 32'h322));
        store_word(3, 32'h324, {{24{word[23]}}, word[23:16]});
        emit(enc_i(32'h03, 4, 4, 0, 32'h322));
        store_word(4, 32'h328, {24'b0, word[23:16]});
        run_program("bytes", byte_cycles);
    endtask

    initial begin
        void'($urandom(73102));
        rst_n = 1'b0;
        preset_en = 1'b0;
        preset_idx = '0;
        preset_data = '0;
        pc_idx = 0;
        for (int i = 0; i < 64; i++) begin
            rom[i] = nop;
        end
        test_alu();
        test_upper();
        test_flow();
        test_bytes();
        // A second reset after a run must restart fetch at zero
        test_upper();
        $display("TB PASSED");
        $finish;
    end

endmodule

// ==== build.f ====
common/isa_pkg.sv
common/core_pkg.sv
decode/instr_decoder.sv
execute/execute_unit.sv
result/result_unit.sv
src/regfile.sv
src/core_top.sv
tests/core_assert.sv
tests/tb_core.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the core testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f build.f --top-module tb_core -o tb_core_sim; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_core_sim > sim.log 2>&1
status=$?
cat sim.log

if grep -q "TB FAILED" sim.log; then
    echo "Simulation reported failure"
    exit 1
fi
if [ "$status" -ne 0 ]; then
    echo "Simulator exited with status $status"
    exit 1
fi
echo "Simulation passed"
exit 0
